//--- compile.f
+incdir+tests
verilog/remap_pkg.sv
verilog/remap_decode.sv
verilog/remap_execute.sv
verilog/remap_result.sv
verilog/remap_unit.sv
tests/tb_remap_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the remap unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f compile.f --top-module tb_remap_unit -o sim_remap
out=$(./obj_dir/sim_remap)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -qx "Everything OK"

//--- tests/remap_model.svh
`ifndef REMAP_MODEL_SVH
`define REMAP_MODEL_SVH

////////////////////
// Lane table
////////////////////

// Active flag and step count k for one lane
function automatic remap_pkg::lane_cfg_t model_lane(
    input int s,
    input int p,
    input int lane
);
    remap_pkg::lane_cfg_t c;
    logic                 legal;

    c     = '0;
    legal = (p == 3 || p == 5 || p == 7) && (p >= s) && (s != 0);
    if (legal && (s % 2 == 1))
    begin
        // Offsets 6 7 0 1 2 3 4 5
        c.active = 1'b1;
        c.offset = remap_pkg::offset_t'((lane + 6) % 8);
    end
    else if (legal && (s == 2 || s == 6) && lane >= 2 && lane <= 5)
    begin
        // Offsets 3 0 1 2 on lanes 2 to 5
        c.active = 1'b1;
        c.offset = remap_pkg::offset_t'((lane + 1) % 4);
    end
    else if (legal && s == 4 && lane >= 6)
    begin
        c.active = 1'b1;
        c.offset = remap_pkg::offset_t'(lane - 6);
    end
    return c;
endfunction

////////////////////
// Window rule
////////////////////

// Positions run 1 to 8, 0 is read as 8
function automatic remap_pkg::window_t model_window(
    input int                  k,
    input int                  s,
    input int                  p,
    input remap_pkg::in_beat_t b
);
    int                 t;
    int                 q;
    remap_pkg::window_t w;

    w = '0;
    t = (1 + k * s) % 8;
    if (t == 0)
    begin
        t = 8;
    end
    for (int i = 0; i < p; i++)
    begin
        q = (t + i) % 8;
        if (q == 0)
        begin
            q = 8;
        end
        if (q >= 10 - p + i)
        begin
            w[i] = b.residues[8 - q];
        end
        else
        begin
            w[i] = b.pixel[q - 1];
        end
    end
    return w;
endfunction

function automatic remap_pkg::out_beat_t model_beat(
    input int                  s,
    input int                  p,
    input remap_pkg::in_beat_t b
);
    remap_pkg::out_beat_t o;
    remap_pkg::lane_cfg_t c;

    o = '0;
    for (int l = 0; l < 8; l++)
    begin
        c         = model_lane(s, p, l);
        o.mask[l] = c.active;
        if (c.active)
        begin
            o.win[l] = model_window(int'(c.offset), s, p, b);
        end
    end
    return o;
endfunction

`endif

//--- tests/tb_remap_unit.sv
`default_nettype none

module tb_remap_unit;

    timeunit 1ns;
    timeprecision 100ps;

    `include "remap_model.svh"

    localparam int FIFO_DEPTH     = 4;
    localparam int OUT_CREDITS    = 2;
    localparam int RANDOM_BEATS   = 50;
    // Stride 1, even strides, invalid pairs, back-pressure, random stream
    localparam int TOTAL_BEATS    = 12 + 12 + 6 + FIFO_DEPTH + RANDOM_BEATS;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 200;

    logic                 clk;
    logic                 rst;
    remap_pkg::stride_t   stride;
    remap_pkg::patch_t    patch;
    logic                 in_valid;
    remap_pkg::in_beat_t  in_beat;
    logic                 in_credit;
    logic                 out_valid;
    remap_pkg::out_beat_t out_beat;
    logic                 out_credit_return = 1'b0;

    remap_pkg::out_beat_t exp_q [$];
    remap_pkg::out_beat_t got_q [$];
    int                   sent_total    = 0;
    int                   credit_pulses = 0;
    int                   owed          = 0;
    int                   cycles        = 0;
    int                   errors        = 0;
    int                   checks        = 0;
    int                   tests_run     = 0;
    int                   seed          = 32'hea91;
    logic                 hold_credits  = 1'b0;
    logic                 random_return = 1'b0;
    logic                 return_next   = 1'b0;

    remap_unit #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_remap_unit (
        .clk               (clk),
        .rst               (rst),
        .stride            (stride),
        .patch             (patch),
        .in_valid          (in_valid),
        .in_beat           (in_beat),
        .in_credit         (in_credit),
        .out_valid         (out_valid),
        .out_beat          (out_beat),
        .out_credit_return (out_credit_return)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////
    // Downstream side
    ////////////////////

    // Sampled mid cycle, a beat seen here leaves at the next edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (out_valid === 1'b1)
            begin
                got_q.push_back(out_beat);
                owed = owed + 1;
            end
            if (in_credit === 1'b1)
            begin
                credit_pulses = credit_pulses + 1;
            end
            return_next = 1'b0;
            if (!hold_credits && owed > 0 && (!random_return || ($random(seed) & 1) == 0))
            begin
                return_next = 1'b1;
                owed        = owed - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        #1;
        out_credit_return = return_next;
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_beat(
        input string                name,
        input remap_pkg::out_beat_t expected,
        input remap_pkg::out_beat_t actual
    );
        checks = checks + 1;
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks = checks + 1;
        if (actual != expected)
        begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run = tests_run + 1;
        if (errors == errors_before)
        begin
            $display("%s: passed", name);
        end
        else
        begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////
    // Upstream side
    ////////////////////

    // All driving tasks start and end 1 ns after a rising edge
    task automatic idle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_config(input int s, input int p);
        stride = remap_pkg::stride_t'(s);
        patch  = remap_pkg::patch_t'(p);
        repeat (2) idle();
    endtask

    task automatic send_beat(input remap_pkg::in_beat_t b);
        while (sent_total - credit_pulses >= FIFO_DEPTH)
        begin
            idle();
        end
        in_valid = 1'b1;
        in_beat  = b;
        exp_q.push_back(model_beat(int'(stride), int'(patch), b));
        sent_total = sent_total + 1;
        idle();
        in_valid = 1'b0;
    endtask

    task automatic send_patterns(input int n);
        remap_pkg::in_beat_t pats [4];

        pats[0] = {8'hA5, 6'h2A};
        pats[1] = {8'hFF, 6'h00};
        pats[2] = {8'h00, 6'h3F};
        pats[3] = {8'h96, 6'h15};
        for (int j = 0; j < n; j++)
        begin
            send_beat(pats[j]);
        end
    endtask

    task automatic drain_and_compare(input string name);
        while (got_q.size() < exp_q.size())
        begin
            idle();
        end
        while (exp_q.size() > 0)
        begin
            check_beat(name, exp_q.pop_front(), got_q.pop_front());
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset();
        int e0;

        e0 = errors;
        repeat (5)
        begin
            @(negedge clk);
            check_count("reset out_valid", 0, int'(out_valid));
            check_count("reset in_credit", 0, int'(in_credit));
        end
        idle();
        report_test("reset", e0);
    endtask

    task automatic test_stride_one();
        int e0;

        e0 = errors;
        for (int p = 3; p <= 7; p += 2)
        begin
            set_config(1, p);
            send_patterns(4);
            drain_and_compare("stride 1");
        end
        report_test("stride 1 patch 3 5 7", e0);
    endtask

    task automatic test_even_strides();
        int e0;

        e0 = errors;
        for (int s = 2; s <= 6; s += 2)
        begin
            set_config(s, 7);
            send_patterns(4);
            drain_and_compare("even stride");
        end
        report_test("strides 2 4 6 patch 7", e0);
    endtask

    task automatic test_invalid_pairs();
        int e0;

        e0 = errors;
        set_config(5, 3);
        send_patterns(3);
        drain_and_compare("stride 5 patch 3");
        set_config(1, 4);
        send_patterns(3);
        drain_and_compare("patch 4");
        report_test("invalid pairs", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int pulses0;

        e0 = errors;
        set_config(1, 7);
        // All downstream credits back before holding them
        while (owed != 0)
        begin
            idle();
        end
        idle();
        hold_credits = 1'b1;
        pulses0      = credit_pulses;
        for (int j = 0; j < FIFO_DEPTH; j++)
        begin
            send_beat(14'($random(seed)));
        end
        repeat (10) idle();
        check_count("back-pressure beats out", OUT_CREDITS, got_q.size());
        hold_credits = 1'b0;
        drain_and_compare("back-pressure");
        check_count("back-pressure in_credit", FIFO_DEPTH, credit_pulses - pulses0);
        report_test("back-pressure", e0);
    endtask

    task automatic test_random_stream();
        int e0;

        e0 = errors;
        set_config(3, 5);
        random_return = 1'b1;
        for (int j = 0; j < RANDOM_BEATS; j++)
        begin
            if (($random(seed) & 3) == 0)
            begin
                idle();
            end
            send_beat(14'($random(seed)));
        end
        drain_and_compare("random stream");
        random_return = 1'b0;
        report_test("random stream", e0);
    endtask

    initial
    begin
        rst      = 1'b1;
        stride   = '0;
        patch    = '0;
        in_valid = 1'b0;
        in_beat  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_stride_one();
        test_even_strides();
        test_invalid_pairs();
        test_backpressure();
        test_random_stream();

        repeat (5) idle();
        check_count("unexpected beats", 0, got_q.size());
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/remap_unit.sv
`default_nettype none

module remap_unit #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  remap_pkg::stride_t   stride,
    input  remap_pkg::patch_t    patch,
    input  logic                 in_valid,
    input  remap_pkg::in_beat_t  in_beat,
    output logic                 in_credit,
    output logic                 out_valid,
    output remap_pkg::out_beat_t out_beat,
    input  logic                 out_credit_return
);

    remap_pkg::lane_table_t lane_cfg;
    logic                   exe_valid;
    remap_pkg::out_beat_t   exe_beat;

    ////////////////////
    // Config decode
    ////////////////////

    remap_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .stride   (stride),
        .patch    (patch),
        .lane_cfg (lane_cfg)
    );

    ////////////////////
    // Window extraction
    ////////////////////

    // Config is only changed with no beats in flight
    remap_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .stride    (stride),
        .patch     (patch),
        .lane_cfg  (lane_cfg),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .exe_valid (exe_valid),
        .exe_beat  (exe_beat)
    );

    ////////////////////
    // Output buffer and credits
    ////////////////////

    remap_result #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_result (
        .clk               (clk),
        .rst               (rst),
        .exe_valid         (exe_valid),
        .exe_beat          (exe_beat),
        .out_credit_return (out_credit_return),
        .out_valid         (out_valid),
        .out_beat          (out_beat),
        .in_credit         (in_credit)
    );

endmodule

`default_nettype wire

//--- verilog/remap_result.sv
`default_nettype none

module remap_result #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exe_valid,
    input  remap_pkg::out_beat_t exe_beat,
    input  logic                 out_credit_return,
    output logic                 out_valid,
    output remap_pkg::out_beat_t out_beat,
    output logic                 in_credit
);

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    // One spare bit of headroom on the credit count
    localparam int CRED_W = $clog2(OUT_CREDITS + 2);

    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [CRED_W-1:0] cred_t;

    remap_pkg::out_beat_t mem [FIFO_DEPTH];
    ptr_t                 wr_ptr;
    ptr_t                 rd_ptr;
    cnt_t                 count;
    cred_t                credits;
    logic                 pop;

    function automatic ptr_t ptr_next(input ptr_t p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    ////////////////////
    // Send decision
    ////////////////////

    // A beat leaves when one is buffered and downstream has room
    always_comb
    begin
        pop = (count != '0) && (credits != '0);
    end

    assign out_valid = pop;
    assign out_beat  = mem[rd_ptr];

    // Each beat sent frees one buffer slot upstream
    assign in_credit = pop;

    ////////////////////
    // Buffer storage
    ////////////////////

    // Upstream credits keep this from overflowing
    always_ff @(posedge clk)
    begin
        if (exe_valid)
        begin
            mem[wr_ptr] <= exe_beat;
        end
    end

    ////////////////////
    // Pointers and counters
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRED_W'(OUT_CREDITS);
        end
        else
        begin
            if (exe_valid)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count   <= count + CNT_W'(exe_valid) - CNT_W'(pop);
            // Return and spend may land in the same cycle
            credits <= credits + CRED_W'(out_credit_return) - CRED_W'(pop);
        end
    end

endmodule

`default_nettype wire

//--- verilog/remap_execute.sv
`default_nettype none

module remap_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  remap_pkg::stride_t     stride,
    input  remap_pkg::patch_t      patch,
    input  remap_pkg::lane_table_t lane_cfg,
    input  logic                   in_valid,
    input  remap_pkg::in_beat_t    in_beat,
    output logic                   exe_valid,
    output remap_pkg::out_beat_t   exe_beat
);

    remap_pkg::out_beat_t next_beat;

    ////////////////////
    // Window rule
    ////////////////////

    // Positions are kept zero based here, so pos is q - 1.
    // Start pos is (k * s) mod 8, which is T - 1 with 0 read as 8.
    function automatic remap_pkg::window_t lane_window(
        input remap_pkg::offset_t  k,
        input remap_pkg::stride_t  s,
        input remap_pkg::patch_t   p,
        input remap_pkg::in_beat_t b
    );
        logic [2:0]         base;
        logic [2:0]         pos;
        remap_pkg::window_t w;

        base = k * s;
        w    = '0;
        for (int i = 0; i < $bits(remap_pkg::window_t); i++)
        begin
            // Wraps within one byte
            pos = base + 3'(i);
            if (i < int'(p))
            begin
                // Tail of the window reaches back into the residues
                if (int'(pos) + int'(p) >= remap_pkg::PIXELS_PER_BEAT + 1 + i)
                begin
                    w[i] = b.residues[remap_pkg::PIXELS_PER_BEAT - 1 - int'(pos)];
                end
                else
                begin
                    w[i] = b.pixel[pos];
                end
            end
        end
        return w;
    endfunction

    ////////////////////
    // Lane windows
    ////////////////////

    always_comb
    begin
        for (int l = 0; l < remap_pkg::NUM_LANES; l++)
        begin
            next_beat.mask[l] = lane_cfg[l].active;
            if (lane_cfg[l].active)
            begin
                next_beat.win[l] = lane_window(lane_cfg[l].offset, stride, patch, in_beat);
            end
            else
            begin
                next_beat.win[l] = '0;
            end
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exe_valid <= 1'b0;
        end
        else
        begin
            exe_valid <= in_valid;
        end
    end

    // New beat every cycle, so several can be in flight
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            exe_beat <= next_beat;
        end
    end

endmodule

`default_nettype wire

//--- verilog/remap_decode.sv
`default_nettype none

module remap_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  remap_pkg::stride_t     stride,
    input  remap_pkg::patch_t      patch,
    output remap_pkg::lane_table_t lane_cfg
);

    logic                   patch_legal;
    logic                   cfg_ok;
    remap_pkg::lane_table_t entry;
    remap_pkg::lane_table_t lane_next;

    ////////////////////
    // Table lookup
    ////////////////////

    // Only odd patch sizes 3 to 7 are supported
    always_comb
    begin
        patch_legal = (patch == 3'd3) || (patch == 3'd5) || (patch == 3'd7);
    end

    // Patch must cover at least one stride step
    always_comb
    begin
        cfg_ok = patch_legal && (patch >= stride);
    end

    always_comb
    begin
        entry = remap_pkg::STRIDE_TABLE[stride];
    end

    // Offsets pass through, active flags are masked by the config check
    always_comb
    begin
        for (int l = 0; l < remap_pkg::NUM_LANES; l++)
        begin
            lane_next[l].active = entry[l].active & cfg_ok;
            lane_next[l].offset = entry[l].offset;
        end
    end

    ////////////////////
    // Registered table
    ////////////////////

    // Execute stage sees a stable table one cycle after a config change
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lane_cfg <= '0;
        end
        else
        begin
            lane_cfg <= lane_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/remap_pkg.sv
`default_nettype none

package remap_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int NUM_LANES       = 8;
    localparam int PIXELS_PER_BEAT = 8;

    // Bit 0 is pixel position 1
    typedef logic [PIXELS_PER_BEAT-1:0] pixel_t;
    // Bit 0 is the residue nearest to the new byte
    typedef logic [5:0]                 residue_t;
    typedef logic [6:0]                 window_t;
    typedef logic [2:0]                 stride_t;
    typedef logic [2:0]                 patch_t;
    // Lane step count k
    typedef logic [2:0]                 offset_t;

    ////////////////////
    // Beats and lane config
    ////////////////////

    typedef struct packed {
        logic    active;
        offset_t offset;
    } lane_cfg_t;

    typedef lane_cfg_t [NUM_LANES-1:0] lane_table_t;

    typedef struct packed {
        pixel_t   pixel;
        residue_t residues;
    } in_beat_t;

    // Lane 0 sits in the low bits of both fields
    typedef struct packed {
        logic [NUM_LANES-1:0]    mask;
        window_t [NUM_LANES-1:0] win;
    } out_beat_t;

    ////////////////////
    // Stride table
    ////////////////////

    // One nibble per lane, {active, offset}, lane 7 leftmost
    // Odd strides use all lanes, offsets 6 7 0 1 2 3 4 5
    localparam lane_table_t LANES_ODD  = 32'hDCBA_98FE;
    // Strides 2 and 6 use lanes 2 to 5, offsets 3 0 1 2
    localparam lane_table_t LANES_EVEN = 32'h00A9_8B00;
    // Stride 4 uses lanes 6 and 7, offsets 0 1
    localparam lane_table_t LANES_FOUR = 32'h9800_0000;

    // Indexed by stride, entry 0 is not a legal stride
    localparam lane_table_t STRIDE_TABLE [0:7] = '{
        32'h0000_0000,
        LANES_ODD,
        LANES_EVEN,
        LANES_ODD,
        LANES_FOUR,
        LANES_ODD,
        LANES_EVEN,
        LANES_ODD
    };

endpackage

`default_nettype wire
